/* verilog.f */
source/poly_pkg.sv
source/beat_fifo.sv
source/stream_ingress.sv
source/horner_column.sv
source/horner_chain.sv
source/stream_egress.sv
source/poly_stream_top.sv
verification/poly_stream_chk.sv
verification/poly_stream_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= poly_stream_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/poly_stream_tb.sv */
`timescale 1ns/1ns

module poly_stream_tb;

    import poly_pkg::*;

    localparam int SEED           = 79747;
    localparam int JOB0_ROWS      = 6;
    localparam int NUM_ROWS       = 66;     // second job long enough to fill both fifos
    localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS;

    typedef struct packed {
        sample_t [NUM_LANES-1:0] x;
        logic [IN_KEEP_W-1:0]    keep;
        logic                    last;
        out_beat_t               exp;
    } row_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [IN_DATA_W-1:0]  i_tdata;
    logic [IN_KEEP_W-1:0]  i_tkeep;
    logic                  i_tlast;
    logic                  i_tvalid;
    logic                  o_tready;
    logic [OUT_DATA_W-1:0] o_tdata;
    logic [OUT_KEEP_W-1:0] o_tkeep;
    logic                  o_tlast;
    logic                  o_tvalid;
    logic                  i_tready;
    logic                  i_start;
    logic                  o_done;
    logic                  i_coef_we;
    coef_wr_t              i_coef;

    row_t        tbl [NUM_ROWS];
    acc_t        coef_set [2][NUM_COL+1];
    int unsigned cycle_cnt = 0;
    logic        saw_stall = 1'b0;

    poly_stream_top u_poly_stream_top (.*);

    always #10 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [OUT_DATA_W-1:0] exp,
                                   input logic [OUT_DATA_W-1:0] got);
        stop_on_error($sformatf("Fail %s expected %0h got %0h", name, exp, got));
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_on_error("timeout: the output beats or the done pulse never arrived");
        end
    end

    // c0*x^3 + c1*x^2 + c2*x + c3 wrapping at 32 bits
    function automatic acc_t poly_value(input int job, input sample_t s);
        acc_t x;
        x = acc_t'(s);
        return coef_set[job][0] * x * x * x + coef_set[job][1] * x * x
             + coef_set[job][2] * x + coef_set[job][3];
    endfunction

    task automatic fill_table();
        logic [IN_KEEP_W-1:0] keep_pat [4];
        logic                 lane_ok;
        int                   job;
        keep_pat = '{8'hff, 8'hff, 8'hdb, 8'h3c};   // full, full, lanes 0+3, lanes 1+2
        for (int r = 0; r < NUM_ROWS; r++) begin
            job = (r < JOB0_ROWS) ? 0 : 1;
            tbl[r].keep = keep_pat[r % 4];
            tbl[r].last = (r == JOB0_ROWS - 1) || (r == NUM_ROWS - 1);
            tbl[r].exp.last = tbl[r].last;
            for (int l = 0; l < NUM_LANES; l++) begin
                tbl[r].x[l] = (r == 0) ? 16'hffff : sample_t'($urandom);
                lane_ok = &tbl[r].keep[l*IN_KEEP_PER_LANE +: IN_KEEP_PER_LANE];
                tbl[r].exp.mask[l] = lane_ok;
                tbl[r].exp.acc[l] = lane_ok ? poly_value(job, tbl[r].x[l]) : '0;
            end
        end
    endtask

    task automatic check_beat(input out_beat_t exp);
        logic [OUT_KEEP_W-1:0] exp_keep;
        for (int l = 0; l < NUM_LANES; l++) begin
            exp_keep[l*OUT_KEEP_PER_LANE +: OUT_KEEP_PER_LANE] = {OUT_KEEP_PER_LANE{exp.mask[l]}};
        end
        if (o_tdata !== exp.acc) report_mismatch("o_tdata", exp.acc, o_tdata);
        if (o_tkeep !== exp_keep) begin
            report_mismatch("o_tkeep", OUT_DATA_W'(exp_keep), OUT_DATA_W'(o_tkeep));
        end
        if (o_tlast !== exp.last) begin
            report_mismatch("o_tlast", OUT_DATA_W'(exp.last), OUT_DATA_W'(o_tlast));
        end
    endtask

    task automatic check_done(input logic exp);
        if (o_done !== exp) report_mismatch("o_done", OUT_DATA_W'(exp), OUT_DATA_W'(o_done));
    endtask

    task automatic check_tready(input logic exp);
        if (o_tready !== exp) report_mismatch("o_tready", OUT_DATA_W'(exp), OUT_DATA_W'(o_tready));
    endtask

    task automatic load_coefs(input int job);
        for (int k = 0; k <= NUM_COL; k++) begin
            @(posedge clk);
            #2;
            i_coef_we   = 1'b1;
            i_coef.idx  = COEF_IDX_W'(k);
            i_coef.value = coef_set[job][k];
        end
        @(posedge clk);
        #2;
        i_coef_we = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #2;
        i_start = 1'b1;
        @(posedge clk);
        #2;
        i_start = 1'b0;
    endtask

    task automatic send_job(input int first, input int last_row);
        logic taken;
        for (int r = first; r <= last_row; r++) begin
            i_tdata  = tbl[r].x;
            i_tkeep  = tbl[r].keep;
            i_tlast  = tbl[r].last;
            i_tvalid = 1'b1;
            do begin
                @(negedge clk);
                taken = o_tready;    // o_tready is steady until the next edge
                if (!taken) begin
                    saw_stall = 1'b1;    // ingress full under back-pressure
                end
                @(posedge clk);
                #2;
            end while (!taken);
        end
        i_tvalid = 1'b0;
    endtask

    task automatic collect_job(input int first, input int last_row, input bit throttle);
        int r;
        r = first;
        while (r <= last_row) begin
            @(negedge clk);
            check_done(1'b0);
            if (o_tvalid && i_tready) begin
                check_beat(tbl[r].exp);
                r++;
            end
            @(posedge clk);
            #2;
            i_tready = throttle ? (($urandom % 4) == 0) : 1'b1;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        i_tdata = '0;
        i_tkeep = '0;
        i_tlast = 1'b0;
        i_tvalid = 1'b0;
        i_tready = 1'b0;
        i_start = 1'b0;
        i_coef_we = 1'b0;
        i_coef = '0;
        coef_set[0] = '{32'h0000_0003, 32'h0000_0005, 32'h0000_0007, 32'h0000_000b};
        coef_set[1] = '{32'h1234_5678, 32'hdead_0001, 32'h0000_0100, 32'h8000_0001};
        fill_table();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // a beat is offered while idle and must be neither taken nor produced
        i_tdata  = tbl[0].x;
        i_tkeep  = tbl[0].keep;
        i_tvalid = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_tready(1'b0);
            if (o_tvalid) stop_on_error("an output beat appeared before the job was started");
        end
        @(posedge clk);
        #2;
        i_tvalid = 1'b0;

        for (int job = 0; job < 2; job++) begin
            load_coefs(job);
            pulse_start();
            fork
                send_job(job == 0 ? 0 : JOB0_ROWS, job == 0 ? JOB0_ROWS - 1 : NUM_ROWS - 1);
                collect_job(job == 0 ? 0 : JOB0_ROWS, job == 0 ? JOB0_ROWS - 1 : NUM_ROWS - 1,
                            job == 1);
            join
            @(negedge clk);
            check_done(1'b1);
            @(negedge clk);
            check_done(1'b0);
            check_tready(1'b0);     // back to idle
            if (o_tvalid) stop_on_error("an extra output beat appeared after the job ended");
        end

        if (!saw_stall) begin
            stop_on_error("o_tready never fell while the output side was throttled");
        end

        if (u_poly_stream_top.u_chk.fired) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "the stream checker reported assertion failures");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* verification/poly_stream_chk.sv */
`timescale 1ns/1ns

module poly_stream_chk (
    input logic                            clk,
    input logic                            rst,
    input logic                            i_start,
    input logic                            o_tready,
    input logic                            o_tvalid,
    input logic [poly_pkg::OUT_KEEP_W-1:0] o_tkeep,
    input logic                            o_done
);

    import poly_pkg::*;

    logic running;          // follows the job window from start to done
    logic fired = 1'b0;     // seen by the testbench at the end of the run

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else if (!running) begin
            running <= i_start;
        end else begin
            running <= !o_done;
        end
    end

    function automatic logic keep_groups_ok(input logic [OUT_KEEP_W-1:0] k);
        logic [OUT_KEEP_PER_LANE-1:0] grp;
        logic                         ok;
        ok = 1'b1;
        for (int l = 0; l < NUM_LANES; l++) begin
            grp = k[l*OUT_KEEP_PER_LANE +: OUT_KEEP_PER_LANE];
            ok  = ok && ((&grp) || (grp == '0));   // whole lane or nothing
        end
        return ok;
    endfunction

    a_reset_quiet: assert property (@(posedge clk) rst |=> !(o_tvalid || o_tready || o_done))
        else begin
            $error("output stream or done active in the cycle after reset");
            fired = 1'b1;
        end

    a_done_single: assert property (@(posedge clk) disable iff (rst) o_done |=> !o_done)
        else begin
            $error("o_done stayed high for more than one cycle");
            fired = 1'b1;
        end

    a_keep_groups: assert property (@(posedge clk) disable iff (rst) keep_groups_ok(o_tkeep))
        else begin
            $error("o_tkeep has a lane that is only partly enabled");
            fired = 1'b1;
        end

    a_idle_ready: assert property (@(posedge clk) disable iff (rst) !running |-> !o_tready)
        else begin
            $error("o_tready high while no job is running");
            fired = 1'b1;
        end

endmodule

bind poly_stream_top poly_stream_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .i_start  (i_start),
    .o_tready (o_tready),
    .o_tvalid (o_tvalid),
    .o_tkeep  (o_tkeep),
    .o_done   (o_done)
);

/* source/poly_stream_top.sv */
`timescale 1ns/1ns

module poly_stream_top (
    input  logic                            clk,
    input  logic                            rst,
    // input stream
    input  logic [poly_pkg::IN_DATA_W-1:0]  i_tdata,
    input  logic [poly_pkg::IN_KEEP_W-1:0]  i_tkeep,
    input  logic                            i_tlast,
    input  logic                            i_tvalid,
    output logic                            o_tready,
    // output stream
    output logic [poly_pkg::OUT_DATA_W-1:0] o_tdata,
    output logic [poly_pkg::OUT_KEEP_W-1:0] o_tkeep,
    output logic                            o_tlast,
    output logic                            o_tvalid,
    input  logic                            i_tready,
    // job control
    input  logic                            i_start,
    output logic                            o_done,
    // coefficient load
    input  logic                            i_coef_we,
    input  poly_pkg::coef_wr_t              i_coef
);

    import poly_pkg::*;

    in_beat_t  ing_beat;
    logic      ing_valid;
    logic      chain_advance;
    out_beat_t chain_out;
    logic      chain_push;
    logic      eg_space;

    stream_ingress u_ingress (
        .clk          (clk),
        .rst          (rst),
        .i_tdata      (i_tdata),
        .i_tkeep      (i_tkeep),
        .i_tlast      (i_tlast),
        .i_tvalid     (i_tvalid),
        .i_start      (i_start),
        .i_done       (o_done),        // done closes the run window
        .i_advance    (chain_advance),
        .o_tready     (o_tready),
        .o_beat       (ing_beat),
        .o_beat_valid (ing_valid)
    );

    horner_chain u_chain (
        .clk          (clk),
        .rst          (rst),
        .i_coef_we    (i_coef_we),
        .i_coef       (i_coef),
        .i_beat       (ing_beat),
        .i_beat_valid (ing_valid),
        .i_space      (eg_space),
        .o_advance    (chain_advance),
        .o_out        (chain_out),
        .o_push       (chain_push)
    );

    stream_egress u_egress (
        .clk      (clk),
        .rst      (rst),
        .i_out    (chain_out),
        .i_push   (chain_push),
        .i_tready (i_tready),
        .o_space  (eg_space),
        .o_tdata  (o_tdata),
        .o_tkeep  (o_tkeep),
        .o_tlast  (o_tlast),
        .o_tvalid (o_tvalid),
        .o_done   (o_done)
    );

endmodule

/* source/stream_egress.sv */
`timescale 1ns/1ns

module stream_egress (
    input  logic                            clk,
    input  logic                            rst,
    input  poly_pkg::out_beat_t             i_out,
    input  logic                            i_push,
    input  logic                            i_tready,
    output logic                            o_space,
    output logic [poly_pkg::OUT_DATA_W-1:0] o_tdata,
    output logic [poly_pkg::OUT_KEEP_W-1:0] o_tkeep,
    output logic                            o_tlast,
    output logic                            o_tvalid,
    output logic                            o_done
);

    import poly_pkg::*;

    out_beat_t             head;
    logic                  fifo_empty;
    logic [FIFO_CNT_W-1:0] count;
    logic                  xfer;
    logic                  done_q;

    beat_fifo #(
        .T     (out_beat_t),
        .DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (i_push),
        .i_pop   (xfer),
        .i_din   (i_out),
        .o_dout  (head),
        .o_empty (fifo_empty),
        .o_full  (),
        .o_count (count)
    );

    assign o_tvalid = !fifo_empty;
    assign xfer     = o_tvalid && i_tready;

    // leaves room for the beats still inside the columns
    assign o_space = (count < FIFO_CNT_W'(EGRESS_SPACE));

    assign o_tdata = head.acc;
    assign o_tlast = head.last && o_tvalid;

    // one mask bit per lane becomes four byte enables
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            o_tkeep[l*OUT_KEEP_PER_LANE +: OUT_KEEP_PER_LANE] =
                {OUT_KEEP_PER_LANE{head.mask[l] && o_tvalid}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= xfer && head.last;   // pulse after the last beat leaves
        end
    end

    assign o_done = done_q;

endmodule

/* source/horner_chain.sv */
`timescale 1ns/1ns

module horner_chain (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_coef_we,
    input  poly_pkg::coef_wr_t  i_coef,
    input  poly_pkg::in_beat_t  i_beat,
    input  logic                i_beat_valid,
    input  logic                i_space,
    output logic                o_advance,
    output poly_pkg::out_beat_t o_out,
    output logic                o_push
);

    import poly_pkg::*;

    acc_t coef_q [NUM_COL+1];

    // stage 0 is the ingress head, stage j is the output of column j-1
    logic [NUM_COL:0]        stg_valid;
    logic [NUM_COL:0]        stg_last;
    lane_mask_t              stg_mask [NUM_COL+1];
    sample_t [NUM_LANES-1:0] stg_x    [NUM_COL+1];
    acc_t [NUM_LANES-1:0]    stg_acc  [NUM_COL+1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k <= NUM_COL; k++) begin
                coef_q[k] <= '0;
            end
        end else if (i_coef_we) begin
            coef_q[i_coef.idx] <= i_coef.value;
        end
    end

    assign stg_valid[0] = i_beat_valid;
    assign stg_last[0]  = i_beat.last;
    assign stg_mask[0]  = i_beat.mask;
    assign stg_x[0]     = i_beat.x;
    assign stg_acc[0]   = {NUM_LANES{coef_q[0]}};   // c0 seeds every lane

    genvar j;
    generate
        for (j = 0; j < NUM_COL; j++) begin : g_col
            horner_column u_col (
                .clk     (clk),
                .rst     (rst),
                .i_en    (i_space),
                .i_valid (stg_valid[j]),
                .i_x     (stg_x[j]),
                .i_acc   (stg_acc[j]),
                .i_coef  (coef_q[j+1]),
                .i_mask  (stg_mask[j]),
                .i_last  (stg_last[j]),
                .o_valid (stg_valid[j+1]),
                .o_x     (stg_x[j+1]),
                .o_acc   (stg_acc[j+1]),
                .o_mask  (stg_mask[j+1]),
                .o_last  (stg_last[j+1])
            );
        end
    endgenerate

    // whole chain steps together, frozen when egress is near full
    assign o_advance = i_space;
    assign o_push    = i_space && stg_valid[NUM_COL];

    assign o_out = '{acc: stg_acc[NUM_COL], mask: stg_mask[NUM_COL], last: stg_last[NUM_COL]};

endmodule

/* source/horner_column.sv */
`timescale 1ns/1ns

module horner_column (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             i_en,
    input  logic                                             i_valid,
    input  poly_pkg::sample_t [poly_pkg::NUM_LANES-1:0]      i_x,
    input  poly_pkg::acc_t [poly_pkg::NUM_LANES-1:0]         i_acc,
    input  poly_pkg::acc_t                                   i_coef,
    input  poly_pkg::lane_mask_t                             i_mask,
    input  logic                                             i_last,
    output logic                                             o_valid,
    output poly_pkg::sample_t [poly_pkg::NUM_LANES-1:0]      o_x,
    output poly_pkg::acc_t [poly_pkg::NUM_LANES-1:0]         o_acc,
    output poly_pkg::lane_mask_t                             o_mask,
    output logic                                             o_last
);

    import poly_pkg::*;

    acc_t [NUM_LANES-1:0] acc_next;

    // acc * x + c per lane, product wraps at 32 bits
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            acc_next[l] = i_mask[l] ? (i_acc[l] * ACC_W'(i_x[l]) + i_coef) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else if (i_en) begin
            o_valid <= i_valid;
        end
    end

    // payload moves only with the enable, held otherwise
    always_ff @(posedge clk) begin
        if (i_en) begin
            o_x    <= i_x;          // x rides along for the next step
            o_acc  <= acc_next;
            o_mask <= i_mask;
            o_last <= i_last;
        end
    end

endmodule

/* source/stream_ingress.sv */
`timescale 1ns/1ns

module stream_ingress (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [poly_pkg::IN_DATA_W-1:0] i_tdata,
    input  logic [poly_pkg::IN_KEEP_W-1:0] i_tkeep,
    input  logic                           i_tlast,
    input  logic                           i_tvalid,
    input  logic                           i_start,
    input  logic                           i_done,
    input  logic                           i_advance,
    output logic                           o_tready,
    output poly_pkg::in_beat_t             o_beat,
    output logic                           o_beat_valid
);

    import poly_pkg::*;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } run_state_e;

    run_state_e state_q;
    run_state_e state_d;
    in_beat_t   beat_in;
    logic       fifo_full;
    logic       fifo_empty;
    logic       push;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // job runs from the start strobe to the done pulse
    always_comb begin
        case (state_q)
            ST_IDLE: state_d = i_start ? ST_RUN : ST_IDLE;
            ST_RUN:  state_d = i_done ? ST_IDLE : ST_RUN;
            default: state_d = ST_IDLE;
        endcase
    end

    always_comb begin
        beat_in.x    = i_tdata;
        beat_in.last = i_tlast;
        for (int l = 0; l < NUM_LANES; l++) begin
            // lane counts only with both keep bits set
            beat_in.mask[l] = &i_tkeep[l*IN_KEEP_PER_LANE +: IN_KEEP_PER_LANE];
        end
    end

    assign o_tready     = (state_q == ST_RUN) && !fifo_full;
    assign push         = i_tvalid && o_tready;
    assign o_beat_valid = !fifo_empty;

    beat_fifo #(
        .T     (in_beat_t),
        .DEPTH (FIFO_DEPTH)
    ) u_in_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (push),
        .i_pop   (o_beat_valid && i_advance),
        .i_din   (beat_in),
        .o_dout  (o_beat),
        .o_empty (fifo_empty),
        .o_full  (fifo_full),
        .o_count ()
    );

endmodule

/* source/beat_fifo.sv */
`timescale 1ns/1ns

module beat_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_push,
    input  logic                       i_pop,
    input  T                           i_din,
    output T                           o_dout,
    output logic                       o_empty,
    output logic                       o_full,
    output logic [$clog2(DEPTH+1)-1:0] o_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_count = count;
    assign do_push = i_push && !o_full;    // push on full is dropped
    assign do_pop  = i_pop && !o_empty;
    assign o_dout  = mem[rd_ptr];          // head entry, first-word fall-through

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

/* source/poly_pkg.sv */
package poly_pkg;

    // lane and pipeline geometry
    localparam int NUM_LANES = 4;
    localparam int NUM_COL   = 3;          // one horner step per column
    localparam int SAMPLE_W  = 16;
    localparam int ACC_W     = 32;

    // stream widths
    localparam int IN_KEEP_W  = 8;
    localparam int OUT_KEEP_W = 16;
    localparam int IN_DATA_W  = NUM_LANES * SAMPLE_W;
    localparam int OUT_DATA_W = NUM_LANES * ACC_W;
    localparam int IN_KEEP_PER_LANE  = IN_KEEP_W / NUM_LANES;     // 2 bits per 16-bit lane
    localparam int OUT_KEEP_PER_LANE = OUT_KEEP_W / NUM_LANES;

    // beat fifos
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    // room for every beat still in the columns plus one being pushed
    localparam int EGRESS_SPACE = FIFO_DEPTH - NUM_COL - 1;

    localparam int COEF_IDX_W = $clog2(NUM_COL + 1);

    typedef logic [SAMPLE_W-1:0]  sample_t;
    typedef logic [ACC_W-1:0]     acc_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    typedef struct packed {
        sample_t [NUM_LANES-1:0] x;        // lane 0 in the low bits
        lane_mask_t              mask;
        logic                    last;
    } in_beat_t;

    typedef struct packed {
        acc_t [NUM_LANES-1:0] acc;
        lane_mask_t           mask;
        logic                 last;
    } out_beat_t;

    typedef struct packed {
        logic [COEF_IDX_W-1:0] idx;        // 0 is the highest-order coefficient
        acc_t                  value;
    } coef_wr_t;

endpackage
